// File: include/panel_settings.svh
`ifndef PANEL_SETTINGS_SVH
`define PANEL_SETTINGS_SVH

// Power-on sequencing, in clk cycles
// Consecutive npwron low cycles before power-good
`define PANEL_PWRGOOD_CYCLES 16
// Length of the power-on reset pulse
`define PANEL_RESET_CYCLES 8
// Extra rsthold time once reset has dropped
`define PANEL_RSTHOLD_CYCLES 32

// Step switch autorepeat
// Hold time before the first repeat
`define PANEL_REPEAT_DELAY 40
// Spacing of repeat pulses
`define PANEL_REPEAT_PERIOD 12

// Highest microprogram step that is still fetch
`define PANEL_FETCH_LAST 3

// Memory/I/O sequencer phase lengths
`define PANEL_WAR_CYCLES 1
`define PANEL_RPC_CYCLES 2
`define PANEL_XFER_CYCLES 4
`define PANEL_WRITE_CYCLES 2

`endif

// File: design/panel_pkg.sv
`default_nettype none

package panel_pkg;

   // Microprogram counter from the processor
   typedef logic [3:0] upc_t;

   // Shared by every delay and phase counter
   typedef logic [15:0] cnt_t;

   // One bit per panel switch with start in the msb
   typedef logic [9:0] sw_vec_t;

   // Memory/I/O examine and deposit phases
   typedef enum logic [1:0] {
      MC_IDLE,
      MC_ADDR,
      MC_XFER,
      MC_RELEASE
   } mc_phase_e;

   // Run flip-flop
   // Free run from start/cont, step run ends on the next fetch
   typedef enum logic [1:0] {
      RUN_STOP,
      RUN_FREE,
      RUN_STEP
   } run_state_e;

endpackage

`default_nettype wire

// File: design/panel_switch_if.sv
`default_nettype none

// Clean panel switch levels, active high
interface panel_switch_if;

   logic start;
   logic stop;
   logic cont;
   logic step;
   logic reset_req;
   // Examine/deposit switches
   logic dep_mem;
   logic dep_io;
   logic exam_mem;
   logic exam_io;
   // Upward push of any examine/deposit switch
   logic inc_addr;

   // Synchronizer side
   modport src (
      output start, stop, cont, step, reset_req,
      output dep_mem, dep_io, exam_mem, exam_io, inc_addr
   );

   // Consumers
   modport dst (
      input start, stop, cont, step, reset_req,
      input dep_mem, dep_io, exam_mem, exam_io, inc_addr
   );

endinterface

`default_nettype wire

// File: design/panel_switch_sync.sv
`default_nettype none

module panel_switch_sync (
   input wire clk,
   input wire arst_n,
   // Raw switch contacts, active low
   input wire start_n,
   input wire stop_n,
   input wire cont_n,
   input wire step_n,
   input wire reset_n,
   input wire dep_mem_n,
   input wire dep_io_n,
   input wire exam_mem_n,
   input wire exam_io_n,
   input wire inc_addr_n,
   panel_switch_if.src sw
);

   import panel_pkg::*;

   sw_vec_t raw_n;
   sw_vec_t meta_q;
   sw_vec_t sync_q;

   // Gather all contacts in one vector, start first
   assign raw_n = {start_n, stop_n, cont_n, step_n, reset_n,
                   dep_mem_n, dep_io_n, exam_mem_n, exam_io_n, inc_addr_n};

   // Two flops per switch
   // Inversion on the way in, so both stages hold active-high levels
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         meta_q <= '0;
         sync_q <= '0;
      end else begin
         meta_q <= ~raw_n;
         sync_q <= meta_q;
      end
   end

   // Fan back out onto the interface
   assign sw.start     = sync_q[9];
   assign sw.stop      = sync_q[8];
   assign sw.cont      = sync_q[7];
   assign sw.step      = sync_q[6];
   assign sw.reset_req = sync_q[5];
   assign sw.dep_mem   = sync_q[4];
   assign sw.dep_io    = sync_q[3];
   assign sw.exam_mem  = sync_q[2];
   assign sw.exam_io   = sync_q[1];
   assign sw.inc_addr  = sync_q[0];

endmodule

`default_nettype wire

// File: design/panel_reset_seq.sv
`default_nettype none

`include "panel_settings.svh"

module panel_reset_seq (
   input wire clk,
   input wire arst_n,
   // Supply sense, low while power is on
   input wire npwron,
   panel_switch_if.dst sw,
   output logic powergood,
   output logic reset,
   output logic rsthold
);

   import panel_pkg::*;

   localparam cnt_t PWRGOOD_LAST = cnt_t'(`PANEL_PWRGOOD_CYCLES - 1);
   localparam cnt_t RESET_LEN    = cnt_t'(`PANEL_RESET_CYCLES);
   localparam cnt_t RSTHOLD_LEN  = cnt_t'(`PANEL_RSTHOLD_CYCLES);

   cnt_t pwr_cnt;
   cnt_t rst_cnt;
   cnt_t hold_cnt;
   logic pg_q;
   logic pg_rise;
   logic panel_req;

   ////////////////////////////////////////////////////////////
   // Power-good
   ////////////////////////////////////////////////////////////

   // Needs an unbroken run of npwron low, drops at once on npwron high
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pwr_cnt   <= '0;
         powergood <= 1'b0;
      end else if (npwron) begin
         pwr_cnt   <= '0;
         powergood <= 1'b0;
      end else if (pwr_cnt == PWRGOOD_LAST) begin
         powergood <= 1'b1;
      end else begin
         pwr_cnt <= pwr_cnt + cnt_t'(1);
      end
   end

   ////////////////////////////////////////////////////////////
   // Reset pulse and rsthold stretcher
   ////////////////////////////////////////////////////////////

   assign pg_rise = powergood & ~pg_q;

   // Panel reset from the switches, reset and start together
   assign panel_req = sw.reset_req & sw.start;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pg_q    <= 1'b0;
         rst_cnt <= '0;
      end else begin
         pg_q <= powergood;
         if (pg_rise) begin
            rst_cnt <= RESET_LEN;
         end else if (!powergood) begin
            // Brown-out aborts a pulse in progress
            rst_cnt <= '0;
         end else if (rst_cnt != '0) begin
            rst_cnt <= rst_cnt - cnt_t'(1);
         end
      end
   end

   assign reset = (rst_cnt != '0) | panel_req;

   // Reloaded every cycle reset is high, runs down once it drops
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hold_cnt <= '0;
      end else if (reset) begin
         hold_cnt <= RSTHOLD_LEN;
      end else if (hold_cnt != '0) begin
         hold_cnt <= hold_cnt - cnt_t'(1);
      end
   end

   assign rsthold = reset | (hold_cnt != '0);

endmodule

`default_nettype wire

// File: design/panel_run_ctrl.sv
`default_nettype none

`include "panel_settings.svh"

module panel_run_ctrl (
   input wire clk,
   input wire arst_n,
   panel_switch_if.dst sw,
   input wire powergood,
   // Halt request written by the processor
   input wire halt_req,
   input wire panel_pkg::upc_t upc,
   output logic isrun,
   output logic isstop,
   output logic clken,
   output logic step,
   output logic isfetch,
   output logic isexecute
);

   import panel_pkg::*;

   localparam upc_t FETCH_LAST   = upc_t'(`PANEL_FETCH_LAST);
   localparam cnt_t REPEAT_DELAY = cnt_t'(`PANEL_REPEAT_DELAY);
   localparam cnt_t REPEAT_PER   = cnt_t'(`PANEL_REPEAT_PERIOD);

   run_state_e run_state;
   cnt_t rep_cnt;
   logic step_sw_q;
   logic start_cont_q;
   logic fetch_q;
   logic start_cont;
   logic start_rise;
   logic step_press;
   logic repeat_fire;
   logic step_fire;
   logic fetch_rise;
   logic run_clear;

   ////////////////////////////////////////////////////////////
   // Fetch/execute decode
   ////////////////////////////////////////////////////////////

   // First steps of every microprogram are fetch
   assign isfetch   = (upc <= FETCH_LAST);
   assign isexecute = ~isfetch;

   ////////////////////////////////////////////////////////////
   // Edge detection
   ////////////////////////////////////////////////////////////

   assign start_cont = sw.start & sw.cont;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         step_sw_q    <= 1'b0;
         start_cont_q <= 1'b0;
         // Starts as fetch, so upc sitting at 0 gives no edge
         fetch_q      <= 1'b1;
      end else begin
         step_sw_q    <= sw.step;
         start_cont_q <= start_cont;
         fetch_q      <= isfetch;
      end
   end

   assign start_rise = start_cont & ~start_cont_q;
   assign step_press = sw.step & ~step_sw_q;
   assign fetch_rise = isfetch & ~fetch_q;

   ////////////////////////////////////////////////////////////
   // Step pulse and autorepeat
   ////////////////////////////////////////////////////////////

   // Long delay after the press, then the short repeat period
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rep_cnt <= '0;
      end else if (!sw.step) begin
         rep_cnt <= '0;
      end else if (step_press) begin
         rep_cnt <= REPEAT_DELAY;
      end else if (rep_cnt == cnt_t'(1)) begin
         rep_cnt <= REPEAT_PER;
      end else if (rep_cnt != '0) begin
         rep_cnt <= rep_cnt - cnt_t'(1);
      end
   end

   assign repeat_fire = sw.step & (rep_cnt == cnt_t'(1));
   assign step_fire   = step_press | repeat_fire;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         step <= 1'b0;
      end else begin
         step <= step_fire;
      end
   end

   ////////////////////////////////////////////////////////////
   // Run flip-flop
   ////////////////////////////////////////////////////////////

   // Every stop source
   // Stop wins over any run request
   assign run_clear = sw.stop | halt_req | ~powergood |
                      ((run_state == RUN_STEP) & fetch_rise);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         run_state <= RUN_STOP;
      end else if (run_clear) begin
         run_state <= RUN_STOP;
      end else if (start_rise) begin
         run_state <= RUN_FREE;
      end else if (step_fire && run_state != RUN_FREE) begin
         // Each step pulse starts a new single instruction
         run_state <= RUN_STEP;
      end
   end

   assign isrun  = (run_state != RUN_STOP);
   assign isstop = ~isrun;
   assign clken  = isrun;

endmodule

`default_nettype wire

// File: design/panel_mem_seq.sv
`default_nettype none

`include "panel_settings.svh"

module panel_mem_seq (
   input wire clk,
   input wire arst_n,
   panel_switch_if.dst sw,
   // Write address register
   output logic war,
   // Read program counter
   output logic rpc,
   output logic mem,
   output logic io,
   output logic r,
   output logic w,
   // Read/write accumulator
   output logic rac,
   output logic wac,
   output logic incpc
);

   import panel_pkg::*;

   localparam cnt_t WAR_LEN   = cnt_t'(`PANEL_WAR_CYCLES);
   localparam cnt_t RPC_LEN   = cnt_t'(`PANEL_RPC_CYCLES);
   localparam cnt_t XFER_LEN  = cnt_t'(`PANEL_XFER_CYCLES);
   localparam cnt_t WRITE_LEN = cnt_t'(`PANEL_WRITE_CYCLES);
   // Address phase covers both war and rpc
   localparam cnt_t ADDR_LEN  = (WAR_LEN > RPC_LEN) ? WAR_LEN : RPC_LEN;

   mc_phase_e phase;
   cnt_t ph_cnt;
   logic any_req;
   logic op_io;
   logic op_read;
   logic is_io_q;
   logic is_read_q;
   logic in_addr;
   logic in_xfer;

   ////////////////////////////////////////////////////////////
   // Switch decode
   ////////////////////////////////////////////////////////////

   assign any_req = sw.dep_mem | sw.dep_io | sw.exam_mem | sw.exam_io;
   assign op_io   = sw.dep_io | sw.exam_io;
   // Examine reads into the accumulator, deposit writes from it
   assign op_read = sw.exam_mem | sw.exam_io;

   // Operation is frozen at the start of a sequence
   always_ff @(posedge clk) begin
      if (phase == MC_IDLE && any_req) begin
         is_io_q   <= op_io;
         is_read_q <= op_read;
      end
   end

   ////////////////////////////////////////////////////////////
   // Phase sequencer
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         phase  <= MC_IDLE;
         ph_cnt <= '0;
      end else begin
         case (phase)
            MC_IDLE: begin
               // Idle is only left after all levels dropped, so high is a rise
               if (any_req) begin
                  phase  <= MC_ADDR;
                  ph_cnt <= '0;
               end
            end
            MC_ADDR: begin
               if (ph_cnt == ADDR_LEN - cnt_t'(1)) begin
                  phase  <= MC_XFER;
                  ph_cnt <= '0;
               end else begin
                  ph_cnt <= ph_cnt + cnt_t'(1);
               end
            end
            MC_XFER: begin
               if (ph_cnt == XFER_LEN - cnt_t'(1)) begin
                  phase  <= MC_RELEASE;
                  ph_cnt <= '0;
               end else begin
                  ph_cnt <= ph_cnt + cnt_t'(1);
               end
            end
            MC_RELEASE: begin
               // One sequence per press
               if (!any_req) begin
                  phase <= MC_IDLE;
               end
            end
            default: begin
               phase  <= MC_IDLE;
               ph_cnt <= '0;
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Strobes
   ////////////////////////////////////////////////////////////

   assign in_addr = (phase == MC_ADDR);
   assign in_xfer = (phase == MC_XFER);

   // Address register takes the PC before the cycle
   assign war = in_addr & (ph_cnt < WAR_LEN);
   assign rpc = in_addr & (ph_cnt < RPC_LEN);

   assign mem = in_xfer & ~is_io_q;
   assign io  = in_xfer & is_io_q;

   // Whole phase on the source side, short strobe on the target side
   assign r   = in_xfer & is_read_q;
   assign wac = in_xfer & is_read_q & (ph_cnt < WRITE_LEN);
   assign rac = in_xfer & ~is_read_q;
   assign w   = in_xfer & ~is_read_q & (ph_cnt < WRITE_LEN);

   // Only with the upward switch push
   assign incpc = in_xfer & sw.inc_addr;

endmodule

`default_nettype wire

// File: design/panel.sv
`default_nettype none

module panel (
   input wire clk,
   input wire arst_n,
   // Supply sense
   input wire npwron,
   // Panel switches, active low
   input wire start_n,
   input wire stop_n,
   input wire cont_n,
   input wire step_n,
   input wire reset_n,
   input wire dep_mem_n,
   input wire dep_io_n,
   input wire exam_mem_n,
   input wire exam_io_n,
   input wire inc_addr_n,
   // From the processor
   input wire halt_req,
   input wire panel_pkg::upc_t upc,
   // Reset outputs
   output logic reset,
   output logic rsthold,
   // Lights and clock control
   output logic isrun,
   output logic isstop,
   output logic clken,
   output logic step,
   output logic isfetch,
   output logic isexecute,
   // Memory/I/O strobes
   output logic war,
   output logic rpc,
   output logic mem,
   output logic io,
   output logic r,
   output logic w,
   output logic rac,
   output logic wac,
   output logic incpc
);

   logic powergood;

   // Clean switch levels shared by all blocks
   panel_switch_if sw_if ();

   panel_switch_sync switch_sync_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .start_n    (start_n),
      .stop_n     (stop_n),
      .cont_n     (cont_n),
      .step_n     (step_n),
      .reset_n    (reset_n),
      .dep_mem_n  (dep_mem_n),
      .dep_io_n   (dep_io_n),
      .exam_mem_n (exam_mem_n),
      .exam_io_n  (exam_io_n),
      .inc_addr_n (inc_addr_n),
      .sw         (sw_if)
   );

   panel_reset_seq reset_seq_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .npwron    (npwron),
      .sw        (sw_if),
      .powergood (powergood),
      .reset     (reset),
      .rsthold   (rsthold)
   );

   panel_run_ctrl run_ctrl_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .sw        (sw_if),
      .powergood (powergood),
      .halt_req  (halt_req),
      .upc       (upc),
      .isrun     (isrun),
      .isstop    (isstop),
      .clken     (clken),
      .step      (step),
      .isfetch   (isfetch),
      .isexecute (isexecute)
   );

   panel_mem_seq mem_seq_i (
      .clk    (clk),
      .arst_n (arst_n),
      .sw     (sw_if),
      .war    (war),
      .rpc    (rpc),
      .mem    (mem),
      .io     (io),
      .r      (r),
      .w      (w),
      .rac    (rac),
      .wac    (wac),
      .incpc  (incpc)
   );

endmodule

`default_nettype wire

// File: bench/panel_tb.sv
`default_nettype none

`include "panel_settings.svh"

module panel_tb;

   import panel_pkg::*;

   ////////////////////////////////////////////////////////////
   // Constants
   ////////////////////////////////////////////////////////////

   // Longest wait for any DUT event, in clk cycles
   localparam int MAX_WAIT = 200;
   // Raw switch to clean level latency
   localparam int SYNC_CYCLES = 2;

   // Pressed switch masks
   // Start sits in the msb
   localparam sw_vec_t SW_START    = 10'b10_0000_0000;
   localparam sw_vec_t SW_STOP     = 10'b01_0000_0000;
   localparam sw_vec_t SW_CONT     = 10'b00_1000_0000;
   localparam sw_vec_t SW_STEP     = 10'b00_0100_0000;
   localparam sw_vec_t SW_RESET    = 10'b00_0010_0000;
   localparam sw_vec_t SW_DEP_MEM  = 10'b00_0001_0000;
   localparam sw_vec_t SW_DEP_IO   = 10'b00_0000_1000;
   localparam sw_vec_t SW_EXAM_MEM = 10'b00_0000_0100;
   localparam sw_vec_t SW_EXAM_IO  = 10'b00_0000_0010;
   localparam sw_vec_t SW_INC_ADDR = 10'b00_0000_0001;

   // Table entry kinds
   localparam int K_POWER  = 0;
   localparam int K_RESET  = 1;
   localparam int K_LEVEL  = 2;
   localparam int K_STEP   = 3;
   localparam int K_REPEAT = 4;
   localparam int K_DECODE = 5;
   localparam int K_MEMSEQ = 6;

   // Signals that wait_for can watch
   localparam int P_RESET   = 0;
   localparam int P_RSTHOLD = 1;
   localparam int P_STEP    = 2;
   localparam int P_STROBE  = 3;

   // Switches held, processor inputs, cycle count and expected level
   typedef struct packed {
      int      kind;
      sw_vec_t sw;
      upc_t    upc;
      logic    halt;
      int      cycles;
      logic    exp;
   } entry_t;

   ////////////////////////////////////////////////////////////
   // DUT and clock
   ////////////////////////////////////////////////////////////

   logic clk;
   logic arst_n;
   logic npwron;
   logic start_n;
   logic stop_n;
   logic cont_n;
   logic step_n;
   logic reset_n;
   logic dep_mem_n;
   logic dep_io_n;
   logic exam_mem_n;
   logic exam_io_n;
   logic inc_addr_n;
   logic halt_req;
   upc_t upc;
   logic reset;
   logic rsthold;
   logic isrun;
   logic isstop;
   logic clken;
   logic step;
   logic isfetch;
   logic isexecute;
   logic war;
   logic rpc;
   logic mem;
   logic io;
   logic r;
   logic w;
   logic rac;
   logic wac;
   logic incpc;
   logic [8:0] strobes;

   entry_t entries[$];

   // Strobe order war, rpc, mem, io, r, w, rac, wac, incpc
   assign strobes = {war, rpc, mem, io, r, w, rac, wac, incpc};

   panel panel_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .npwron     (npwron),
      .start_n    (start_n),
      .stop_n     (stop_n),
      .cont_n     (cont_n),
      .step_n     (step_n),
      .reset_n    (reset_n),
      .dep_mem_n  (dep_mem_n),
      .dep_io_n   (dep_io_n),
      .exam_mem_n (exam_mem_n),
      .exam_io_n  (exam_io_n),
      .inc_addr_n (inc_addr_n),
      .halt_req   (halt_req),
      .upc        (upc),
      .reset      (reset),
      .rsthold    (rsthold),
      .isrun      (isrun),
      .isstop     (isstop),
      .clken      (clken),
      .step       (step),
      .isfetch    (isfetch),
      .isexecute  (isexecute),
      .war        (war),
      .rpc        (rpc),
      .mem        (mem),
      .io         (io),
      .r          (r),
      .w          (w),
      .rac        (rac),
      .wac        (wac),
      .incpc      (incpc)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////

   task automatic abort_run;
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_level(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         $display("FAIL at %0t: %s is %b, expected %b", $time, name, actual, expected);
         abort_run();
      end
   endtask

   task automatic check_upc_phase(input upc_t u, input logic exp_fetch);
      if (isfetch !== exp_fetch || isexecute !== ~exp_fetch) begin
         $display("FAIL at %0t: upc %0d gives fetch %b execute %b, expected fetch %b",
                  $time, u, isfetch, isexecute, exp_fetch);
         abort_run();
      end
   endtask

   task automatic check_strobes(input logic [8:0] expected);
      if (strobes !== expected) begin
         $display("FAIL at %0t: strobes %b, expected %b", $time, strobes, expected);
         abort_run();
      end
   endtask

   task automatic check_count(input string name, input cnt_t actual, input cnt_t expected);
      if (actual !== expected) begin
         $display("FAIL at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
         abort_run();
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Drive and wait helpers
   ////////////////////////////////////////////////////////////

   // Contacts are active low
   task automatic drive_switches(input sw_vec_t pressed);
      {start_n, stop_n, cont_n, step_n, reset_n,
       dep_mem_n, dep_io_n, exam_mem_n, exam_io_n, inc_addr_n} = ~pressed;
   endtask

   task automatic apply_entry(input entry_t e);
      drive_switches(e.sw);
      upc      = e.upc;
      halt_req = e.halt;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   function automatic logic probe(input int sel);
      case (sel)
         P_RESET:   return reset;
         P_RSTHOLD: return rsthold;
         P_STEP:    return step;
         default:   return |strobes;
      endcase
   endfunction

   // Counts falling edges until the watched signal reaches value
   task automatic wait_for(input int sel, input logic value, input string name,
                           output int cycles);
      logic found;
      found  = 1'b0;
      cycles = 0;
      while (!found) begin
         @(negedge clk);
         cycles++;
         if (probe(sel) === value) begin
            found = 1'b1;
         end else if (cycles >= MAX_WAIT) begin
            $display("Timed out after %0d cycles waiting for %s", cycles, name);
            abort_run();
         end
      end
   endtask

   task automatic add_entry(input int kind, input sw_vec_t sw, input int upc_val,
                            input logic halt, input int cycles, input logic exp);
      entry_t e;
      e.kind   = kind;
      e.sw     = sw;
      e.upc    = upc_t'(upc_val);
      e.halt   = halt;
      e.cycles = cycles;
      e.exp    = exp;
      entries.push_back(e);
   endtask

   ////////////////////////////////////////////////////////////
   // Scenario tasks
   ////////////////////////////////////////////////////////////

   task automatic after_reset_check;
      check_level("isrun", isrun, 1'b0);
      check_level("isstop", isstop, 1'b1);
      check_level("clken", clken, 1'b0);
      check_level("step", step, 1'b0);
      check_level("rsthold", rsthold, 1'b0);
      check_strobes(9'b0);
   endtask

   // Power-good delay, reset pulse, then the rsthold stretch
   task automatic power_on_check;
      int cycles;
      npwron = 1'b0;
      wait_for(P_RESET, 1'b1, "reset rise", cycles);
      check_count("cycles to reset", cnt_t'(cycles), cnt_t'(`PANEL_PWRGOOD_CYCLES + 1));
      check_level("rsthold", rsthold, 1'b1);
      wait_for(P_RESET, 1'b0, "reset fall", cycles);
      check_count("reset length", cnt_t'(cycles), cnt_t'(`PANEL_RESET_CYCLES));
      wait_for(P_RSTHOLD, 1'b0, "rsthold fall", cycles);
      check_count("rsthold stretch", cnt_t'(cycles), cnt_t'(`PANEL_RSTHOLD_CYCLES));
   endtask

   task automatic reset_level_check(input entry_t e);
      apply_entry(e);
      wait_cycles(e.cycles);
      check_level("reset", reset, e.exp);
      // High during reset and for the stretch after it
      check_level("rsthold", rsthold, 1'b1);
   endtask

   task automatic run_level_check(input entry_t e);
      apply_entry(e);
      wait_cycles(e.cycles);
      check_level("isrun", isrun, e.exp);
      check_level("clken", clken, e.exp);
      check_level("isstop", isstop, ~e.exp);
   endtask

   task automatic step_press_check(input entry_t e);
      int cycles;
      apply_entry(e);
      wait_for(P_STEP, 1'b1, "step pulse", cycles);
      check_count("step latency", cnt_t'(cycles), cnt_t'(e.cycles));
      check_level("isrun", isrun, e.exp);
      @(negedge clk);
      // Single cycle pulse
      check_level("step", step, 1'b0);
   endtask

   // Step held for e.cycles
   // Every pulse position is checked
   task automatic repeat_check(input entry_t e);
      int n;
      int first;
      int last;
      int exp_count;
      logic is_pulse;
      cnt_t pulses;
      first  = SYNC_CYCLES + 1;
      // Held level stays on the clean side two cycles past release
      last   = e.cycles + SYNC_CYCLES;
      pulses = '0;
      exp_count = 0;
      if (last >= first) begin
         exp_count = 1;
      end
      if (last >= first + `PANEL_REPEAT_DELAY) begin
         exp_count = exp_count + 1 +
                     (last - first - `PANEL_REPEAT_DELAY) / `PANEL_REPEAT_PERIOD;
      end
      apply_entry(e);
      for (n = 1; n <= e.cycles + SYNC_CYCLES + 2; n++) begin
         @(negedge clk);
         is_pulse = (n == first) ||
                    ((n >= first + `PANEL_REPEAT_DELAY) &&
                     ((n - first - `PANEL_REPEAT_DELAY) % `PANEL_REPEAT_PERIOD == 0));
         is_pulse = is_pulse && (n <= last);
         check_level("step", step, is_pulse);
         if (step) begin
            pulses = pulses + cnt_t'(1);
         end
         if (n == e.cycles) begin
            drive_switches('0);
         end
      end
      check_count("step pulses", pulses, cnt_t'(exp_count));
      check_level("isrun", isrun, e.exp);
   endtask

   task automatic decode_sweep;
      int u;
      for (u = 0; u < 16; u++) begin
         upc = upc_t'(u);
         @(negedge clk);
         check_upc_phase(upc_t'(u), u <= `PANEL_FETCH_LAST);
      end
   endtask

   // Expected strobe vector at step k of a sequence
   function automatic logic [8:0] expected_strobes(input int k, input logic is_io,
                                                   input logic is_read, input logic inc);
      int addr_len;
      int j;
      logic xfer;
      logic [8:0] v;
      addr_len = (`PANEL_WAR_CYCLES > `PANEL_RPC_CYCLES) ?
                 `PANEL_WAR_CYCLES : `PANEL_RPC_CYCLES;
      j    = k - addr_len;
      xfer = (j >= 0) && (j < `PANEL_XFER_CYCLES);
      v[8] = (k < `PANEL_WAR_CYCLES);
      v[7] = (k < `PANEL_RPC_CYCLES);
      v[6] = xfer & ~is_io;
      v[5] = xfer & is_io;
      v[4] = xfer & is_read;
      v[3] = xfer & ~is_read & (j < `PANEL_WRITE_CYCLES);
      v[2] = xfer & ~is_read;
      v[1] = xfer & is_read & (j < `PANEL_WRITE_CYCLES);
      v[0] = xfer & inc;
      return v;
   endfunction

   task automatic mem_seq_check(input entry_t e);
      int cycles;
      int k;
      int total;
      logic is_io;
      logic is_read;
      logic inc;
      is_io   = |(e.sw & (SW_DEP_IO | SW_EXAM_IO));
      is_read = |(e.sw & (SW_EXAM_MEM | SW_EXAM_IO));
      inc     = |(e.sw & SW_INC_ADDR);
      total   = ((`PANEL_WAR_CYCLES > `PANEL_RPC_CYCLES) ?
                 `PANEL_WAR_CYCLES : `PANEL_RPC_CYCLES) + `PANEL_XFER_CYCLES;
      apply_entry(e);
      wait_for(P_STROBE, 1'b1, "memory strobes", cycles);
      // Sequencer leaves idle one cycle after the clean level rises
      check_count("strobe latency", cnt_t'(cycles), cnt_t'(SYNC_CYCLES + 1));
      for (k = 0; k < total; k++) begin
         if (k > 0) begin
            @(negedge clk);
         end
         check_strobes(expected_strobes(k, is_io, is_read, inc));
      end
      // No second sequence while the switch is held
      repeat (e.cycles) begin
         @(negedge clk);
         check_strobes(9'b0);
      end
      drive_switches('0);
      repeat (SYNC_CYCLES + 2) begin
         @(negedge clk);
         check_strobes(9'b0);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus table and main loop
   ////////////////////////////////////////////////////////////

   initial begin
      arst_n   = 1'b0;
      npwron   = 1'b1;
      halt_req = 1'b0;
      upc      = '0;
      drive_switches('0);

      //        kind      switches                     upc halt cycles          exp
      add_entry(K_POWER,  '0,                          0,  0,   0,              1);
      add_entry(K_RESET,  SW_RESET | SW_START,         0,  0,   SYNC_CYCLES,    1);
      add_entry(K_RESET,  '0,                          0,  0,   SYNC_CYCLES,    0);
      add_entry(K_LEVEL,  SW_START | SW_CONT,          0,  0,   SYNC_CYCLES + 1, 1);
      add_entry(K_LEVEL,  '0,                          0,  0,   SYNC_CYCLES + 1, 1);
      add_entry(K_LEVEL,  SW_STOP,                     0,  0,   SYNC_CYCLES + 1, 0);
      add_entry(K_LEVEL,  '0,                          0,  0,   SYNC_CYCLES + 1, 0);
      add_entry(K_LEVEL,  SW_START | SW_CONT,          0,  0,   SYNC_CYCLES + 1, 1);
      add_entry(K_LEVEL,  SW_START | SW_CONT,          0,  1,   1,              0);
      add_entry(K_LEVEL,  '0,                          0,  0,   SYNC_CYCLES + 1, 0);
      add_entry(K_LEVEL,  SW_START | SW_CONT | SW_STOP, 0, 0,   SYNC_CYCLES + 1, 0);
      add_entry(K_LEVEL,  SW_START | SW_CONT,          0,  0,   SYNC_CYCLES + 1, 0);
      add_entry(K_LEVEL,  '0,                          0,  0,   SYNC_CYCLES + 1, 0);
      add_entry(K_STEP,   SW_STEP,                     5,  0,   SYNC_CYCLES + 1, 1);
      add_entry(K_LEVEL,  '0,                          5,  0,   SYNC_CYCLES + 1, 1);
      add_entry(K_LEVEL,  '0,                          0,  0,   1,              0);
      add_entry(K_REPEAT, SW_STEP,                     5,  0,   100,            1);
      add_entry(K_LEVEL,  '0,                          0,  0,   1,              0);
      add_entry(K_DECODE, '0,                          0,  0,   0,              0);
      add_entry(K_MEMSEQ, SW_EXAM_MEM,                 0,  0,   10,             0);
      add_entry(K_MEMSEQ, SW_EXAM_MEM | SW_INC_ADDR,   0,  0,   10,             0);
      add_entry(K_MEMSEQ, SW_DEP_MEM,                  0,  0,   10,             0);
      add_entry(K_MEMSEQ, SW_DEP_MEM | SW_INC_ADDR,    0,  0,   10,             0);
      add_entry(K_MEMSEQ, SW_EXAM_IO,                  0,  0,   10,             0);
      add_entry(K_MEMSEQ, SW_EXAM_IO | SW_INC_ADDR,    0,  0,   10,             0);
      add_entry(K_MEMSEQ, SW_DEP_IO,                   0,  0,   10,             0);
      add_entry(K_MEMSEQ, SW_DEP_IO | SW_INC_ADDR,     0,  0,   10,             0);

      wait_cycles(10);
      arst_n = 1'b1;
      @(negedge clk);
      after_reset_check();

      foreach (entries[i]) begin
         case (entries[i].kind)
            K_POWER:  power_on_check();
            K_RESET:  reset_level_check(entries[i]);
            K_LEVEL:  run_level_check(entries[i]);
            K_STEP:   step_press_check(entries[i]);
            K_REPEAT: repeat_check(entries[i]);
            K_DECODE: decode_sweep();
            K_MEMSEQ: mem_seq_check(entries[i]);
            default: begin
               $display("Table entry %0d has an unknown kind", i);
               abort_run();
            end
         endcase
      end

      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: panel.f
+incdir+include
design/panel_pkg.sv
design/panel_switch_if.sv
design/panel_switch_sync.sv
design/panel_reset_seq.sv
design/panel_run_ctrl.sv
design/panel_mem_seq.sv
design/panel.sv
bench/panel_tb.sv

// File: Makefile
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --top-module panel_tb -f panel.f --Mdir $(OBJ_DIR) -o panel_tb
	@out=$$(./$(OBJ_DIR)/panel_tb); echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
